//--- frontend_pkg.sv
// Shared front-end definitions.
// Data width, condition and opcode field codes, reset address,
// FSM state encodings, micro-op kinds and the two stage payloads.

package frontend_pkg;

//////////////////////////////////////////////////
// Widths and constants.
//////////////////////////////////////////////////

// Data and address width.
localparam int unsigned XLEN = 32;

// Always condition code.
localparam logic [3:0] COND_AL = 4'hE;

// Bits 27:25 for B/BL.
localparam logic [2:0] OP_BRANCH = 3'b101;

// Bits 27:25 for LDM/STM.
localparam logic [2:0] OP_BLOCK = 3'b100;

// First fetch address out of reset.
localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

//////////////////////////////////////////////////
// State encodings.
//////////////////////////////////////////////////

// APB phase of the fetch requester.
typedef enum logic [1:0]
{
        FETCH_IDLE,
        FETCH_SETUP,
        FETCH_ACCESS
} fetch_phase_t;

// Block transfer expansion.
typedef enum logic
{
        SEQ_IDLE,
        SEQ_EXPAND
} seq_state_t;

//////////////////////////////////////////////////
// Payloads.
//////////////////////////////////////////////////

// Micro-op kinds.
typedef enum logic [1:0]
{
        UOP_PASS,       // Plain instruction.
        UOP_BRANCH,     // B or BL.
        UOP_XFER,       // One register of LDM/STM.
        UOP_NOP         // Empty register list.
} uop_kind_t;

// Fetch to pre-decode word.
typedef struct packed
{
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic            irq;
} fetch_word_t;

// Pre-decode to back end micro-op.
typedef struct packed
{
        uop_kind_t       kind;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic [3:0]      reg_idx;  // Transfer register.
        logic [7:0]      offset;   // Words from base.
        logic            last;     // Final uop of instruction.
        logic            taken;    // Predicted direction.
        logic            irq;
} uop_t;

endpackage

//--- stage_reg.sv
// One-entry pipeline holding register.
// Payload given as a type parameter; valid/ready handshake with
// flush, clear and back-pressure.

`timescale 1ns/100ps

module stage_reg #(parameter type PAYLOAD_T = logic)
(
        input  logic     i_clk,
        input  logic     i_reset,
        input  logic     i_flush,     // Highest after reset.
        input  logic     i_clear,     // Squash entry.
        input  logic     i_valid,
        output logic     o_ready,
        input  PAYLOAD_T i_data,
        output logic     o_valid,
        output PAYLOAD_T o_data,
        input  logic     i_ready
);

// Free when empty or drained this cycle.
always_comb
begin
        o_ready = !o_valid || i_ready;
end

// Valid bit. Reset, flush, clear, load, then hold.
always_ff @(posedge i_clk)
begin
        if (i_reset)
                o_valid <= 1'b0;
        else if (i_flush)
                o_valid <= 1'b0;
        else if (i_clear)
                o_valid <= 1'b0;
        else if (o_ready)
                o_valid <= i_valid;
end

// Payload only follows the load.
always_ff @(posedge i_clk)
begin
        if (o_ready && i_valid)
                o_data <= i_data;
end

endmodule

//--- fetch_stage.sv
// Instruction fetch.
// PC generation, APB read requester with one transfer in flight,
// stale-read drop after redirect or flush, one-word hold buffer
// and IRQ pending bit.

`timescale 1ns/100ps

module fetch_stage
(
        input  logic                          i_clk,
        input  logic                          i_reset,
        input  logic                          i_flush,
        input  logic [frontend_pkg::XLEN-1:0] i_flush_pc,
        input  logic                          i_redirect,
        input  logic [frontend_pkg::XLEN-1:0] i_redirect_pc,
        input  logic                          i_irq,

        // APB requester.
        output logic                          o_psel,
        output logic                          o_penable,
        output logic [frontend_pkg::XLEN-1:0] o_paddr,
        input  logic [frontend_pkg::XLEN-1:0] i_prdata,
        input  logic                          i_pready,
        input  logic                          i_pslverr,

        // To fetch register.
        output logic                          o_valid,
        output frontend_pkg::fetch_word_t     o_word,
        input  logic                          i_ready
);

import frontend_pkg::*;

fetch_phase_t    phase_q;
logic [XLEN-1:0] pc_q;          // Next address to request.
logic [XLEN-1:0] addr_q;        // Address on the bus.
logic            stale_q;
logic            hold_q;
logic [XLEN-1:0] hold_instr_q;
logic            irq_pend_q;
logic            done;
logic            live_valid;
logic [XLEN-1:0] live_instr;
logic            restart;
logic            start;
logic [XLEN-1:0] next_pc;

//////////////////////////////////////////////////
// Transfer status.
//////////////////////////////////////////////////

always_comb
begin
        done       = (phase_q == FETCH_ACCESS) && i_pready;
        live_valid = done && !stale_q;

        // Error response becomes an undefined word.
        live_instr = i_pslverr ? '0 : i_prdata;

        // Flush wins over redirect.
        restart = i_flush || i_redirect;
        if (i_flush)
                next_pc = i_flush_pc;
        else if (i_redirect)
                next_pc = i_redirect_pc;
        else
                next_pc = pc_q;
end

// Start a setup phase next cycle.
always_comb
begin
        case (phase_q)
        FETCH_IDLE:   start = restart || !hold_q || i_ready;
        FETCH_ACCESS: start = i_pready && (restart || stale_q || i_ready);
        default:      start = 1'b0;
        endcase
end

//////////////////////////////////////////////////
// Outputs.
//////////////////////////////////////////////////

always_comb
begin
        o_psel       = (phase_q != FETCH_IDLE);
        o_penable    = (phase_q == FETCH_ACCESS);
        o_paddr      = addr_q;
        o_valid      = hold_q || live_valid;
        o_word.pc    = addr_q;
        o_word.instr = hold_q ? hold_instr_q : live_instr;
        o_word.irq   = irq_pend_q;
end

//////////////////////////////////////////////////
// State.
//////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                phase_q <= FETCH_IDLE;
                pc_q    <= RESET_PC;
                addr_q  <= RESET_PC;
                stale_q <= 1'b0;
                hold_q  <= 1'b0;
        end
        else
        begin
                // APB phase.
                if (start)
                        phase_q <= FETCH_SETUP;
                else if (phase_q == FETCH_SETUP)
                        phase_q <= FETCH_ACCESS;
                else if (done)
                        phase_q <= FETCH_IDLE;

                // Address latched at setup.
                if (start)
                begin
                        addr_q <= next_pc;
                        pc_q   <= next_pc + XLEN'(4);
                end
                else if (restart)
                begin
                        pc_q <= next_pc;
                end

                // Transfer in flight at a restart is stale.
                if (done)
                        stale_q <= 1'b0;
                else if (restart && (phase_q != FETCH_IDLE))
                        stale_q <= 1'b1;

                // Hold word when register is full.
                if (restart)
                        hold_q <= 1'b0;
                else if (live_valid && !i_ready)
                        hold_q <= 1'b1;
                else if (i_ready)
                        hold_q <= 1'b0;
        end
end

// Held instruction word.
always_ff @(posedge i_clk)
begin
        if (live_valid && !i_ready)
                hold_instr_q <= live_instr;
end

// IRQ rides on the next accepted word.
always_ff @(posedge i_clk)
begin
        if (i_reset)
                irq_pend_q <= 1'b0;
        else if (i_irq)
                irq_pend_q <= 1'b1;
        else if (o_valid && i_ready && !restart)
                irq_pend_q <= 1'b0;
end

endmodule

//--- uop_sequencer.sv
// Block transfer micro-op sequencer.
// Expands LDM/STM register lists into one micro-op per register,
// lowest register first, and holds its input until the last one.

`timescale 1ns/100ps

module uop_sequencer
(
        input  logic                          i_clk,
        input  logic                          i_reset,
        input  logic                          i_flush,
        input  logic                          i_valid,
        input  logic [frontend_pkg::XLEN-1:0] i_instr,
        input  logic [frontend_pkg::XLEN-1:0] i_pc,
        output logic                          o_ready,
        output logic                          o_valid,
        output frontend_pkg::uop_kind_t       o_kind,
        output logic [3:0]                    o_reg_idx,
        output logic [7:0]                    o_offset,
        output logic                          o_last,
        output logic                          o_first,
        input  logic                          i_ready
);

import frontend_pkg::*;

seq_state_t      state_q;
logic [15:0]     mask_q;        // Registers still to emit.
logic [7:0]      off_q;
logic [XLEN-1:0] blk_pc_q;      // Instruction being expanded.
logic            is_block;
logic            mid;
logic [15:0]     cur_mask;
logic [15:0]     rest_mask;
logic [7:0]      cur_off;

//////////////////////////////////////////////////
// Current register selection.
//////////////////////////////////////////////////

always_comb
begin
        is_block = (i_instr[27:25] == OP_BLOCK);

        // Continue only on the same held word.
        mid = (state_q == SEQ_EXPAND) && (i_pc == blk_pc_q);

        cur_mask  = mid ? mask_q : i_instr[15:0];
        cur_off   = mid ? off_q : 8'd0;
        rest_mask = cur_mask & (cur_mask - 16'd1);
end

// Lowest set register.
always_comb
begin: find_low
        int i;

        o_reg_idx = 4'd0;
        for (i = 15; i >= 0; i--)
        begin
                if (cur_mask[i])
                        o_reg_idx = 4'(i);
        end
end

//////////////////////////////////////////////////
// Micro-op fields.
//////////////////////////////////////////////////

always_comb
begin
        o_valid  = i_valid;
        o_offset = cur_off;
        o_first  = !mid;

        if (!is_block)
                o_kind = UOP_PASS;
        else if (cur_mask == 16'd0)
                o_kind = UOP_NOP;
        else
                o_kind = UOP_XFER;

        o_last = !is_block || (cur_mask == 16'd0) || (rest_mask == 16'd0);

        // Upstream word taken with its last uop.
        o_ready = i_ready && o_last;
end

//////////////////////////////////////////////////
// FSM.
//////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
                state_q <= SEQ_IDLE;
        else if (i_flush)
                state_q <= SEQ_IDLE;
        else if (i_valid && i_ready)
                state_q <= o_last ? SEQ_IDLE : SEQ_EXPAND;
end

// Remaining list, offset and owner.
always_ff @(posedge i_clk)
begin
        if (i_valid && i_ready && !o_last)
        begin
                mask_q   <= rest_mask;
                off_q    <= cur_off + 8'd1;
                blk_pc_q <= i_pc;
        end
end

endmodule

//--- predecode_stage.sv
// Pre-decode stage.
// B/BL detection, target computation and static prediction,
// fetch redirect, IRQ gating, block transfer sequencer.

`timescale 1ns/100ps

module predecode_stage
(
        input  logic                          i_clk,
        input  logic                          i_reset,
        input  logic                          i_flush,

        // From fetch register.
        input  logic                          i_valid,
        input  frontend_pkg::fetch_word_t     i_word,
        output logic                          o_ready,

        // To output register.
        output logic                          o_valid,
        output frontend_pkg::uop_t            o_uop,
        input  logic                          i_ready,

        // To fetch.
        output logic                          o_redirect,
        output logic [frontend_pkg::XLEN-1:0] o_redirect_pc
);

import frontend_pkg::*;

logic            is_branch;
logic            predict;
logic [XLEN-1:0] br_off;
logic            taken;
logic            seq_ready;
logic            seq_valid;
uop_kind_t       seq_kind;
logic [3:0]      seq_reg;
logic [7:0]      seq_off;
logic            seq_last;
logic            seq_first;

//////////////////////////////////////////////////
// Branch resolution.
//////////////////////////////////////////////////

always_comb
begin
        is_branch = (i_word.instr[27:25] == OP_BRANCH);

        // Word offset, sign extended.
        br_off = {{6{i_word.instr[23]}}, i_word.instr[23:0], 2'b00};

        // Always, or backward.
        predict = (i_word.instr[31:28] == COND_AL) || i_word.instr[23];
        taken   = is_branch && predict;

        // Target is pc + 8 + offset.
        o_redirect_pc = i_word.pc + XLEN'(8) + br_off;

        // Only when the sequencer takes the branch.
        o_redirect = i_valid && taken && seq_ready;
end

//////////////////////////////////////////////////
// Block transfer expansion.
//////////////////////////////////////////////////

uop_sequencer u_seq
(
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_flush   (i_flush),
        .i_valid   (i_valid),
        .i_instr   (i_word.instr),
        .i_pc      (i_word.pc),
        .o_ready   (seq_ready),
        .o_valid   (seq_valid),
        .o_kind    (seq_kind),
        .o_reg_idx (seq_reg),
        .o_offset  (seq_off),
        .o_last    (seq_last),
        .o_first   (seq_first),
        .i_ready   (i_ready)
);

//////////////////////////////////////////////////
// Micro-op assembly.
//////////////////////////////////////////////////

always_comb
begin
        o_ready = seq_ready;
        o_valid = seq_valid;

        o_uop.kind    = is_branch ? UOP_BRANCH : seq_kind;
        o_uop.pc      = i_word.pc;
        o_uop.instr   = i_word.instr;
        o_uop.reg_idx = seq_reg;
        o_uop.offset  = seq_off;
        o_uop.last    = seq_last;
        o_uop.taken   = taken;

        // Interrupt only at an instruction boundary.
        o_uop.irq = i_word.irq && seq_first;
end

endmodule

//--- frontend_top.sv
// Front-end top.
// Fetch, fetch register, pre-decode and output register;
// APB requester and micro-op output ports.

`timescale 1ns/100ps

module frontend_top
(
        input  logic                          i_clk,
        input  logic                          i_reset,
        input  logic                          i_flush,
        input  logic [frontend_pkg::XLEN-1:0] i_flush_pc,
        input  logic                          i_irq,

        // APB to instruction memory.
        output logic                          o_psel,
        output logic                          o_penable,
        output logic                          o_pwrite,
        output logic [frontend_pkg::XLEN-1:0] o_paddr,
        input  logic [frontend_pkg::XLEN-1:0] i_prdata,
        input  logic                          i_pready,
        input  logic                          i_pslverr,

        // Micro-op output.
        output logic                          o_uop_valid,
        output frontend_pkg::uop_kind_t       o_uop_kind,
        output logic [frontend_pkg::XLEN-1:0] o_uop_pc,
        output logic [frontend_pkg::XLEN-1:0] o_uop_instr,
        output logic [3:0]                    o_uop_reg,
        output logic [7:0]                    o_uop_offset,
        output logic                          o_uop_last,
        output logic                          o_uop_taken,
        output logic                          o_uop_irq,
        input  logic                          i_uop_ready
);

import frontend_pkg::*;

logic            f_valid;
fetch_word_t     f_word;
logic            f_ready;
logic            fr_valid;
fetch_word_t     fr_word;
logic            fr_ready;
logic            pd_valid;
uop_t            pd_uop;
logic            pd_ready;
uop_t            out_uop;
logic            redirect;
logic [XLEN-1:0] redirect_pc;

// Read-only requester.
assign o_pwrite = 1'b0;

fetch_stage u_fetch
(
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_flush       (i_flush),
        .i_flush_pc    (i_flush_pc),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_irq         (i_irq),
        .o_psel        (o_psel),
        .o_penable     (o_penable),
        .o_paddr       (o_paddr),
        .i_prdata      (i_prdata),
        .i_pready      (i_pready),
        .i_pslverr     (i_pslverr),
        .o_valid       (f_valid),
        .o_word        (f_word),
        .i_ready       (f_ready)
);

// Squashed on a taken branch.
stage_reg #(.PAYLOAD_T(fetch_word_t)) u_freg
(
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_clear (redirect),
        .i_valid (f_valid),
        .o_ready (f_ready),
        .i_data  (f_word),
        .o_valid (fr_valid),
        .o_data  (fr_word),
        .i_ready (fr_ready)
);

predecode_stage u_predecode
(
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_flush       (i_flush),
        .i_valid       (fr_valid),
        .i_word        (fr_word),
        .o_ready       (fr_ready),
        .o_valid       (pd_valid),
        .o_uop         (pd_uop),
        .i_ready       (pd_ready),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
);

stage_reg #(.PAYLOAD_T(uop_t)) u_oreg
(
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_clear (1'b0),
        .i_valid (pd_valid),
        .o_ready (pd_ready),
        .i_data  (pd_uop),
        .o_valid (o_uop_valid),
        .o_data  (out_uop),
        .i_ready (i_uop_ready)
);

// Micro-op fields to loose ports.
assign o_uop_kind   = out_uop.kind;
assign o_uop_pc     = out_uop.pc;
assign o_uop_instr  = out_uop.instr;
assign o_uop_reg    = out_uop.reg_idx;
assign o_uop_offset = out_uop.offset;
assign o_uop_last   = out_uop.last;
assign o_uop_taken  = out_uop.taken;
assign o_uop_irq    = out_uop.irq;

endmodule

//--- tb_apb_imem.sv
// APB completer for the testbench.
// Word-addressed instruction array, per-word error flags and a
// programmable wait-state count per access phase.

`timescale 1ns/100ps

module tb_apb_imem
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_psel,
        input  logic        i_penable,
        input  logic [31:0] i_paddr,
        output logic [31:0] o_prdata,
        output logic        o_pready,
        output logic        o_pslverr,
        input  logic [3:0]  i_wait
);

// 256 words filled by the testbench.
logic [31:0] mem [0:255];
// Error response per word.
logic        err [0:255];
logic [3:0]  wait_cnt;

// Ready once the wait count is used up.
always_comb
begin
        o_pready  = i_psel && i_penable && (wait_cnt == i_wait);
        o_prdata  = mem[i_paddr[9:2]];
        o_pslverr = o_pready && err[i_paddr[9:2]];
end

// Wait-state counter, one step per access cycle.
always_ff @(posedge i_clk)
begin
        if (i_reset)
                wait_cnt <= 4'd0;
        else if (i_psel && i_penable && !o_pready)
                wait_cnt <= wait_cnt + 4'd1;
        else
                wait_cnt <= 4'd0;
end

endmodule

//--- tb_frontend.sv
// Front-end testbench.
// Clock and reset, instruction memory, reference walk of the
// program, directed tests, compare tasks and the summary line.

`timescale 1ns/100ps

module tb_frontend;

import frontend_pkg::*;

logic            clk;
logic            reset;
logic            flush;
logic [31:0]     flush_pc;
logic            irq;
logic            psel;
logic            penable;
logic            pwrite;
logic [31:0]     paddr;
logic [31:0]     prdata;
logic            pready;
logic            pslverr;
logic [3:0]      wait_states;
logic            uop_valid;
uop_kind_t       uop_kind;
logic [31:0]     uop_pc;
logic [31:0]     uop_instr;
logic [3:0]      uop_reg;
logic [7:0]      uop_offset;
logic            uop_last;
logic            uop_taken;
logic            uop_irq;
logic            uop_ready;

logic [31:0]     rng;
logic [31:0]     imem_copy [0:255];
int              err_mismatch;
int              err_other;

// Expected micro-ops in order.
uop_kind_t       exp_kind [$];
logic [31:0]     exp_pc [$];
logic [31:0]     exp_instr [$];
logic [3:0]      exp_reg [$];
logic [7:0]      exp_off [$];
logic            exp_last [$];
logic            exp_taken [$];

frontend_top dut0
(
        .i_clk (clk), .i_reset (reset), .i_flush (flush), .i_flush_pc (flush_pc),
        .i_irq (irq), .o_psel (psel), .o_penable (penable), .o_pwrite (pwrite),
        .o_paddr (paddr), .i_prdata (prdata), .i_pready (pready),
        .i_pslverr (pslverr), .o_uop_valid (uop_valid), .o_uop_kind (uop_kind),
        .o_uop_pc (uop_pc), .o_uop_instr (uop_instr), .o_uop_reg (uop_reg),
        .o_uop_offset (uop_offset), .o_uop_last (uop_last),
        .o_uop_taken (uop_taken), .o_uop_irq (uop_irq), .i_uop_ready (uop_ready)
);

tb_apb_imem u_mem
(
        .i_clk (clk), .i_reset (reset), .i_psel (psel), .i_penable (penable),
        .i_paddr (paddr), .o_prdata (prdata), .o_pready (pready),
        .o_pslverr (pslverr), .i_wait (wait_states)
);

// 10 ns clock.
always #5 clk = !clk;

//////////////////////////////////////////////////
// Helpers.
//////////////////////////////////////////////////

function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
endfunction

task automatic check_kind(input string name, input uop_kind_t got, input uop_kind_t exp);
        if (got !== exp)
        begin
                err_mismatch++;
                $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                err_mismatch++;
                $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
endtask

task automatic check_small(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
                err_mismatch++;
                $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
endtask

// Plain words everywhere tagged with the word index.
task automatic fill_memory();
        int i;

        for (i = 0; i < 256; i++)
        begin
                imem_copy[i]   = 32'hE100_0000 | i;
                u_mem.mem[i]   = 32'hE100_0000 | i;
                u_mem.err[i]   = 1'b0;
        end
        exp_kind.delete();
        exp_pc.delete();
        exp_instr.delete();
        exp_reg.delete();
        exp_off.delete();
        exp_last.delete();
        exp_taken.delete();
endtask

task automatic put_word(input logic [31:0] addr, input logic [31:0] word);
        imem_copy[addr[9:2]] = word;
        u_mem.mem[addr[9:2]] = word;
endtask

// Error response on one word, seen by pre-decode as instr 0.
task automatic put_error(input logic [31:0] addr, input logic [31:0] word);
        imem_copy[addr[9:2]] = 32'd0;
        u_mem.mem[addr[9:2]] = word;
        u_mem.err[addr[9:2]] = 1'b1;
endtask

// Reset held for 4 cycles from the falling edge.
task automatic apply_reset(input logic [3:0] waits);
        @(negedge clk);
        reset       = 1'b1;
        wait_states = waits;
        repeat (4) @(negedge clk);
        reset = 1'b0;
endtask

task automatic push_uop(input uop_kind_t k, input logic [31:0] pc, input logic [31:0] w,
                        input logic [3:0] r, input logic [7:0] off, input logic last,
                        input logic tk);
        exp_kind.push_back(k);
        exp_pc.push_back(pc);
        exp_instr.push_back(w);
        exp_reg.push_back(r);
        exp_off.push_back(off);
        exp_last.push_back(last);
        exp_taken.push_back(tk);
endtask

// Reference walk by sequential PC, static prediction and register lists.
task automatic build_expected(input logic [31:0] start_pc, input int count);
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] off;
        logic        tk;
        int          n;
        int          k;
        int          r;

        pc = start_pc;
        n  = 0;
        while (n < count)
        begin
                w = imem_copy[pc[9:2]];
                if (w[27:25] == 3'b101)
                begin
                        // Byte offset is four times the signed word offset.
                        off = $signed(w[23:0]) * 4;
                        tk  = (w[31:28] == 4'hE) || off[31];
                        push_uop(UOP_BRANCH, pc, w, 4'd0, 8'd0, 1'b1, tk);
                        n++;
                        pc = tk ? pc + 32'd8 + off : pc + 32'd4;
                end
                else if (w[27:25] == 3'b100)
                begin
                        if (w[15:0] == 16'd0)
                        begin
                                push_uop(UOP_NOP, pc, w, 4'd0, 8'd0, 1'b1, 1'b0);
                                n++;
                        end
                        k = 0;
                        for (r = 0; r < 16; r++)
                        begin
                                if (w[r] && n < count)
                                begin
                                        push_uop(UOP_XFER, pc, w, 4'(r), 8'(k),
                                                 (w[15:0] >> (r + 1)) == 16'd0, 1'b0);
                                        k++;
                                        n++;
                                end
                        end
                        pc = pc + 32'd4;
                end
                else
                begin
                        push_uop(UOP_PASS, pc, w, 4'd0, 8'd0, 1'b1, 1'b0);
                        n++;
                        pc = pc + 32'd4;
                end
        end
endtask

// Collects the expected micro-ops with an optional flush or IRQ after an index.
task automatic collect_uops(input bit rand_ready, input int flush_at,
                            input logic [31:0] restart_pc, input int irq_at);
        int idx;
        int cycles;
        int irq_seen;

        idx      = 0;
        cycles   = 0;
        irq_seen = 0;
        while (idx < exp_kind.size() && cycles < 400 + 40 * exp_kind.size())
        begin
                @(negedge clk);
                cycles++;
                flush     = 1'b0;
                irq       = 1'b0;
                uop_ready = rand_ready ? (next_rand() % 4 != 0) : 1'b1;
                // Read-only requester.
                if (psel)
                        check_small("o_pwrite", pwrite, 1'b0);
                // Output register contents are stable between edges.
                if (uop_valid && uop_ready)
                begin
                        check_kind("o_uop_kind", uop_kind, exp_kind[idx]);
                        check_word("o_uop_pc", uop_pc, exp_pc[idx]);
                        check_word("o_uop_instr", uop_instr, exp_instr[idx]);
                        if (exp_kind[idx] == UOP_XFER)
                                check_small("o_uop_reg", uop_reg, exp_reg[idx]);
                        check_small("o_uop_offset", uop_offset, exp_off[idx]);
                        check_small("o_uop_last", uop_last, exp_last[idx]);
                        check_small("o_uop_taken", uop_taken, exp_taken[idx]);
                        if (irq_at < 0)
                                check_small("o_uop_irq", uop_irq, 1'b0);
                        else if (uop_irq)
                        begin
                                irq_seen++;
                                // A boundary follows the last micro-op of an instruction.
                                if (idx <= irq_at || !exp_last[idx - 1])
                                begin
                                        err_other++;
                                        $display("IRQ seen on micro-op %0d, not a boundary", idx);
                                end
                        end
                        if (idx == flush_at)
                        begin
                                flush    = 1'b1;
                                flush_pc = restart_pc;
                        end
                        if (idx == irq_at)
                                irq = 1'b1;
                        idx++;
                end
        end
        if (idx < exp_kind.size())
        begin
                err_other++;
                $display("Timeout, %0d of %0d micro-ops arrived", idx, exp_kind.size());
        end
        if (irq_at >= 0 && irq_seen != 1)
        begin
                err_other++;
                $display("IRQ appeared on %0d micro-ops instead of one", irq_seen);
        end
        @(negedge clk);
        flush     = 1'b0;
        irq       = 1'b0;
        uop_ready = 1'b1;
endtask

//////////////////////////////////////////////////
// Directed tests.
//////////////////////////////////////////////////

task automatic test_sequential(input logic [3:0] waits);
        fill_memory();
        put_error(32'h0C, 32'hEA00_0003);       // Branch pattern under an error.
        build_expected(RESET_PC, 12);
        apply_reset(waits);
        collect_uops(1'b0, -1, 32'd0, -1);
endtask

task automatic test_branches();
        fill_memory();
        put_word(32'h04, 32'hEA00_0003);        // B always to 0x18.
        put_word(32'h08, 32'h0A00_0010);        // BEQ forward is not taken.
        put_word(32'h18, 32'h1AFF_FFFA);        // BNE back to 0x08.
        build_expected(RESET_PC, 20);
        apply_reset(4'(next_rand() % 3));
        collect_uops(1'b0, -1, 32'd0, -1);
endtask

task automatic test_block_list();
        fill_memory();
        put_word(32'h00, 32'hE890_8025);
        put_word(32'h04, 32'hE890_0000);        // Empty list.
        build_expected(RESET_PC, 10);
        apply_reset(4'd0);
        collect_uops(1'b0, -1, 32'd0, -1);
endtask

task automatic test_backpressure();
        fill_memory();
        put_word(32'h00, 32'hE890_8025);
        put_word(32'h08, 32'hEAFF_FFFC);        // Loop to 0x00.
        build_expected(RESET_PC, 40);
        apply_reset(4'(next_rand() % 3));
        collect_uops(1'b1, -1, 32'd0, -1);
endtask

task automatic test_flush_mid_block();
        fill_memory();
        put_word(32'h00, 32'hE890_8025);
        build_expected(RESET_PC, 2);
        build_expected(32'h80, 6);
        apply_reset(4'd1);
        collect_uops(1'b0, 1, 32'h80, -1);
endtask

task automatic test_irq_boundary();
        fill_memory();
        put_word(32'h04, 32'hE890_8025);
        put_word(32'h08, 32'hE890_8025);        // Next block picks up the IRQ.
        build_expected(RESET_PC, 12);
        apply_reset(4'd0);
        collect_uops(1'b0, -1, 32'd0, 2);
endtask

//////////////////////////////////////////////////
// Run.
//////////////////////////////////////////////////

initial
begin
        clk          = 1'b0;
        reset        = 1'b1;
        flush        = 1'b0;
        flush_pc     = 32'd0;
        irq          = 1'b0;
        wait_states  = 4'd0;
        uop_ready    = 1'b1;
        rng          = 32'h5dcfbed4;
        err_mismatch = 0;
        err_other    = 0;

        test_sequential(4'd0);
        test_sequential(4'(1 + next_rand() % 3));
        test_branches();
        test_block_list();
        test_backpressure();
        test_flush_mid_block();
        test_irq_boundary();

        $display("Errors: %0d mismatches, %0d other", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0)
                $display(">>> PASS");
        else
                $display(">>> FAIL");
        $finish;
end

// Whole-run limit.
initial
begin
        #2000000;
        $display("Simulation limit reached before the tests ended");
        $display(">>> FAIL");
        $finish;
end

endmodule

//--- frontend_top.f
frontend_pkg.sv
stage_reg.sv
fetch_stage.sv
uop_sequencer.sv
predecode_stage.sv
frontend_top.sv
tb_apb_imem.sv
tb_frontend.sv
